/* common/isa_pkg.sv */
package isa_pkg;

    // field positions inside the 32-bit instruction word
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int IMM_LSB = 20;  // I-type immediate, 12 bits
    localparam int F7_LSB  = 25;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;  // also MUL under F7_MULDIV
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_SUB    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

/* common/core_pkg.sv */
package core_pkg;

    localparam int XLEN              = 32;
    localparam int NUM_ARCH_REGS     = 32;
    localparam int DEFAULT_ROB_DEPTH = 8;

    // one product bit per iteration
    localparam int MUL_CYCLES = 32;

    typedef logic [4:0] arch_reg_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL,
        OP_ILLEGAL
    } alu_op_t;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE  // product waits here for the result bus
    } mul_state_t;

endpackage

/* common/dispatch_if.sv */
interface dispatch_if #(
    parameter int ROB_DEPTH = core_pkg::DEFAULT_ROB_DEPTH
);
    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic                     valid;
    core_pkg::alu_op_t        op;
    logic [TAG_W-1:0]         tag;   // rob slot of this instruction
    core_pkg::arch_reg_t      rd;

    logic                     src1_ready;
    logic [TAG_W-1:0]         src1_tag;
    logic [core_pkg::XLEN-1:0] src1_value;
    logic                     src2_ready;
    logic [TAG_W-1:0]         src2_tag;
    logic [core_pkg::XLEN-1:0] src2_value;

    modport source (
        output valid, op, tag, rd,
        output src1_ready, src1_tag, src1_value,
        output src2_ready, src2_tag, src2_value
    );

    modport sink (
        input valid, op, tag, rd,
        input src1_ready, src1_tag, src1_value,
        input src2_ready, src2_tag, src2_value
    );

endinterface

/* common/issue_if.sv */
interface issue_if #(
    parameter int ROB_DEPTH = core_pkg::DEFAULT_ROB_DEPTH
);
    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic                      valid;
    core_pkg::alu_op_t         op;
    logic [TAG_W-1:0]          tag;
    logic [core_pkg::XLEN-1:0] operand_a;
    logic [core_pkg::XLEN-1:0] operand_b;
    logic                      alu_ready;
    logic                      mul_ready;

    modport source (output valid, op, tag, operand_a, operand_b, input alu_ready, mul_ready);
    modport sink (input valid, op, tag, operand_a, operand_b, output alu_ready, mul_ready);

endinterface

/* rename/decode_rename.sv */
module decode_rename #(
    parameter int ROB_DEPTH = core_pkg::DEFAULT_ROB_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      inst_valid,
    input  logic [31:0]               inst,
    dispatch_if.source                dispatch,
    input  logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
    output logic [$clog2(ROB_DEPTH)-1:0] lookup_tag1,
    output logic [$clog2(ROB_DEPTH)-1:0] lookup_tag2,
    input  logic                      lookup_ready1,
    input  logic                      lookup_ready2,
    input  logic [core_pkg::XLEN-1:0] lookup_value1,
    input  logic [core_pkg::XLEN-1:0] lookup_value2,
    input  logic                      retire_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] retire_tag,
    input  core_pkg::arch_reg_t       retire_rd,
    input  logic [core_pkg::XLEN-1:0] retire_value
);
    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int XLEN  = core_pkg::XLEN;

    logic [6:0]          opcode;
    logic [2:0]          f3;
    logic [6:0]          f7;
    core_pkg::arch_reg_t rs1, rs2, rd;
    logic [XLEN-1:0]     imm;
    core_pkg::alu_op_t   op;
    logic                use_imm;

    // alias table and architectural registers
    logic [core_pkg::NUM_ARCH_REGS-1:0] rat_busy;
    logic [TAG_W-1:0]                   rat_tag [core_pkg::NUM_ARCH_REGS];
    logic [XLEN-1:0]                    arf     [core_pkg::NUM_ARCH_REGS];

    assign opcode = inst[6:0];
    assign f3     = inst[isa_pkg::F3_LSB +: 3];
    assign f7     = inst[isa_pkg::F7_LSB +: 7];
    assign rd     = inst[isa_pkg::RD_LSB +: 5];
    assign rs1    = inst[isa_pkg::RS1_LSB +: 5];
    assign rs2    = inst[isa_pkg::RS2_LSB +: 5];
    assign imm    = {{(XLEN-12){inst[31]}}, inst[isa_pkg::IMM_LSB +: 12]};

    always_comb begin
        op      = core_pkg::OP_ILLEGAL;
        use_imm = 1'b0;
        if (opcode == isa_pkg::OPC_OP) begin
            if (f7 == isa_pkg::F7_MULDIV && f3 == isa_pkg::F3_ADD_SUB) begin
                op = core_pkg::OP_MUL;
            end else if (f7 == isa_pkg::F7_SUB && f3 == isa_pkg::F3_ADD_SUB) begin
                op = core_pkg::OP_SUB;
            end else if (f7 == isa_pkg::F7_BASE) begin
                case (f3)
                    isa_pkg::F3_ADD_SUB: op = core_pkg::OP_ADD;
                    isa_pkg::F3_XOR:     op = core_pkg::OP_XOR;
                    isa_pkg::F3_OR:      op = core_pkg::OP_OR;
                    isa_pkg::F3_AND:     op = core_pkg::OP_AND;
                    default:             op = core_pkg::OP_ILLEGAL;
                endcase
            end
        end else if (opcode == isa_pkg::OPC_OP_IMM && f3 == isa_pkg::F3_ADD_SUB) begin
            op      = core_pkg::OP_ADD;  // addi
            use_imm = 1'b1;
        end
    end

    assign lookup_tag1 = rat_tag[rs1];
    assign lookup_tag2 = rat_tag[rs2];

    // renamed instruction leaves in the same cycle
    assign dispatch.valid      = inst_valid;
    assign dispatch.op         = op;
    assign dispatch.tag        = alloc_tag;
    assign dispatch.rd         = rd;
    assign dispatch.src1_tag   = rat_tag[rs1];
    assign dispatch.src1_ready = rat_busy[rs1] ? lookup_ready1 : 1'b1;
    assign dispatch.src1_value = rat_busy[rs1] ? lookup_value1 : arf[rs1];
    assign dispatch.src2_tag   = rat_tag[rs2];
    assign dispatch.src2_ready = use_imm || !rat_busy[rs2] || lookup_ready2;
    assign dispatch.src2_value = use_imm ? imm : rat_busy[rs2] ? lookup_value2 : arf[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rat_busy <= '0;
            for (int r = 0; r < core_pkg::NUM_ARCH_REGS; r++) begin
                arf[r] <= '0;
            end
        end else begin
            if (retire_valid && retire_rd != '0) begin
                arf[retire_rd] <= retire_value;
                if (rat_tag[retire_rd] == retire_tag) begin
                    rat_busy[retire_rd] <= 1'b0;  // no younger writer renamed it
                end
            end
            // new rename wins over a same-edge clear
            if (inst_valid && rd != '0) begin
                rat_busy[rd] <= 1'b1;
                rat_tag[rd]  <= alloc_tag;
            end
        end
    end

endmodule

/* issue/reservation_station.sv */
module reservation_station #(
    parameter int ROB_DEPTH = core_pkg::DEFAULT_ROB_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst_n,
    dispatch_if.sink                  dispatch,
    issue_if.source                   issue,
    input  logic                      result_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] result_tag,
    input  logic [core_pkg::XLEN-1:0] result_value
);
    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int XLEN  = core_pkg::XLEN;

    logic [ROB_DEPTH-1:0] ent_valid;
    core_pkg::alu_op_t    ent_op  [ROB_DEPTH];
    logic [TAG_W-1:0]     ent_tag [ROB_DEPTH];
    logic [TAG_W-1:0]     age     [ROB_DEPTH];  // dispatches seen since entry arrived
    logic [ROB_DEPTH-1:0] s1_rdy, s2_rdy;
    logic [TAG_W-1:0]     s1_tag  [ROB_DEPTH];
    logic [TAG_W-1:0]     s2_tag  [ROB_DEPTH];
    logic [XLEN-1:0]      s1_val  [ROB_DEPTH];
    logic [XLEN-1:0]      s2_val  [ROB_DEPTH];

    logic [ROB_DEPTH-1:0] can_issue;
    logic                 sel_found;
    logic [TAG_W-1:0]     sel_idx, free_idx;

    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            can_issue[i] = ent_valid[i] && s1_rdy[i] && s2_rdy[i] &&
                           (ent_op[i] == core_pkg::OP_MUL ? issue.mul_ready : issue.alu_ready);
        end
    end

    // oldest ready entry wins
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (can_issue[i] && (!sel_found || age[i] > age[sel_idx])) begin
                sel_found = 1'b1;
                sel_idx   = TAG_W'(i);
            end
        end
    end

    always_comb begin
        free_idx = '0;
        for (int i = ROB_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) free_idx = TAG_W'(i);
        end
    end

    assign issue.valid     = sel_found;
    assign issue.op        = ent_op[sel_idx];
    assign issue.tag       = ent_tag[sel_idx];
    assign issue.operand_a = s1_val[sel_idx];
    assign issue.operand_b = s2_val[sel_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ent_valid <= '0;
        end else begin
            if (sel_found) ent_valid[sel_idx] <= 1'b0;
            if (dispatch.valid) ent_valid[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (result_valid && !s1_rdy[i] && s1_tag[i] == result_tag) begin
                s1_rdy[i] <= 1'b1;
                s1_val[i] <= result_value;
            end
            if (result_valid && !s2_rdy[i] && s2_tag[i] == result_tag) begin
                s2_rdy[i] <= 1'b1;
                s2_val[i] <= result_value;
            end
            if (dispatch.valid && ent_valid[i]) age[i] <= age[i] + 1'b1;
        end
        if (dispatch.valid) begin
            ent_op[free_idx]  <= dispatch.op;
            ent_tag[free_idx] <= dispatch.tag;
            age[free_idx]     <= '0;
            s1_rdy[free_idx]  <= dispatch.src1_ready;
            s1_tag[free_idx]  <= dispatch.src1_tag;
            s1_val[free_idx]  <= dispatch.src1_value;
            s2_rdy[free_idx]  <= dispatch.src2_ready;
            s2_tag[free_idx]  <= dispatch.src2_tag;
            s2_val[free_idx]  <= dispatch.src2_value;
        end
    end

endmodule

/* execute/int_execute.sv */
module int_execute #(
    parameter int ROB_DEPTH = core_pkg::DEFAULT_ROB_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst_n,
    issue_if.sink                     issue,
    output logic                      result_valid,
    output logic [$clog2(ROB_DEPTH)-1:0] result_tag,
    output logic [core_pkg::XLEN-1:0] result_value
);
    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int XLEN  = core_pkg::XLEN;
    localparam int CNT_W = $clog2(core_pkg::MUL_CYCLES);

    logic                 alu_fire, mul_fire;
    logic [XLEN-1:0]      alu_result;

    core_pkg::mul_state_t mul_state;
    logic [CNT_W-1:0]     mul_cnt;
    logic [TAG_W-1:0]     mul_tag;
    logic [XLEN-1:0]      mul_acc, mul_mcand, mul_mplier, mul_step;

    assign alu_fire = issue.valid && issue.op != core_pkg::OP_MUL;
    assign mul_fire = issue.valid && issue.op == core_pkg::OP_MUL;

    assign mul_step = mul_acc + (mul_mplier[0] ? mul_mcand : '0);

    // product owns the bus on the edge leaving MUL_DONE
    assign issue.alu_ready = (mul_state != core_pkg::MUL_DONE);
    assign issue.mul_ready = (mul_state == core_pkg::MUL_IDLE);

    always_comb begin
        case (issue.op)
            core_pkg::OP_ADD: alu_result = issue.operand_a + issue.operand_b;
            core_pkg::OP_SUB: alu_result = issue.operand_a - issue.operand_b;
            core_pkg::OP_AND: alu_result = issue.operand_a & issue.operand_b;
            core_pkg::OP_OR:  alu_result = issue.operand_a | issue.operand_b;
            core_pkg::OP_XOR: alu_result = issue.operand_a ^ issue.operand_b;
            default:          alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_state <= core_pkg::MUL_IDLE;
        end else begin
            case (mul_state)
                core_pkg::MUL_IDLE: if (mul_fire) mul_state <= core_pkg::MUL_RUN;
                core_pkg::MUL_RUN: begin
                    if (mul_cnt == CNT_W'(core_pkg::MUL_CYCLES - 1)) begin
                        mul_state <= core_pkg::MUL_DONE;
                    end
                end
                default: mul_state <= core_pkg::MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mul_state == core_pkg::MUL_IDLE && mul_fire) begin
            // first partial product taken on the issue edge
            mul_tag    <= issue.tag;
            mul_acc    <= issue.operand_b[0] ? issue.operand_a : '0;
            mul_mcand  <= issue.operand_a << 1;
            mul_mplier <= issue.operand_b >> 1;
            mul_cnt    <= CNT_W'(1);
        end else if (mul_state == core_pkg::MUL_RUN) begin
            mul_acc    <= mul_step;
            mul_mcand  <= mul_mcand << 1;
            mul_mplier <= mul_mplier >> 1;
            mul_cnt    <= mul_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else if (mul_state == core_pkg::MUL_DONE) begin
            result_valid <= 1'b1;
            result_tag   <= mul_tag;
            result_value <= mul_acc;
        end else begin
            result_valid <= alu_fire;
            result_tag   <= issue.tag;
            result_value <= alu_result;
        end
    end

endmodule

/* retire/reorder_buffer.sv */
module reorder_buffer #(
    parameter int ROB_DEPTH = core_pkg::DEFAULT_ROB_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst_n,
    dispatch_if.sink                  dispatch,
    output logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
    input  logic [$clog2(ROB_DEPTH)-1:0] lookup_tag1,
    input  logic [$clog2(ROB_DEPTH)-1:0] lookup_tag2,
    output logic                      lookup_ready1,
    output logic                      lookup_ready2,
    output logic [core_pkg::XLEN-1:0] lookup_value1,
    output logic [core_pkg::XLEN-1:0] lookup_value2,
    input  logic                      result_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] result_tag,
    input  logic [core_pkg::XLEN-1:0] result_value,
    output logic                      retire_valid,
    output logic [$clog2(ROB_DEPTH)-1:0] retire_tag,
    output core_pkg::arch_reg_t       retire_rd,
    output logic [core_pkg::XLEN-1:0] retire_value,
    output logic                      credit_return
);
    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic [TAG_W-1:0]          head, tail;
    logic [TAG_W:0]            count;
    logic [ROB_DEPTH-1:0]      done;
    core_pkg::arch_reg_t       ent_rd    [ROB_DEPTH];
    logic [core_pkg::XLEN-1:0] ent_value [ROB_DEPTH];
    logic                      fwd1, fwd2;

    assign alloc_tag = tail;

    // bus result is visible to rename in the cycle it is broadcast
    assign fwd1          = result_valid && result_tag == lookup_tag1;
    assign fwd2          = result_valid && result_tag == lookup_tag2;
    assign lookup_ready1 = done[lookup_tag1] || fwd1;
    assign lookup_ready2 = done[lookup_tag2] || fwd2;
    assign lookup_value1 = fwd1 ? result_value : ent_value[lookup_tag1];
    assign lookup_value2 = fwd2 ? result_value : ent_value[lookup_tag2];

    assign retire_valid  = (count != '0) && done[head];
    assign retire_tag    = head;
    assign retire_rd     = ent_rd[head];
    assign retire_value  = ent_value[head];
    assign credit_return = retire_valid;  // one credit per retirement

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (result_valid) done[result_tag] <= 1'b1;
            if (dispatch.valid) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;  // wraps, depth is a power of two
            end
            if (retire_valid) head <= head + 1'b1;
            count <= count + (TAG_W+1)'(dispatch.valid) - (TAG_W+1)'(retire_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch.valid) ent_rd[tail] <= dispatch.rd;
        if (result_valid) ent_value[result_tag] <= result_value;
    end

endmodule

/* source/ooo_core_top.sv */
module ooo_core_top #(
    parameter int ROB_DEPTH = core_pkg::DEFAULT_ROB_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      inst_valid,
    input  logic [31:0]               inst,
    output logic                      credit_return,
    output logic                      retire_valid,
    output core_pkg::arch_reg_t       retire_rd,
    output logic [core_pkg::XLEN-1:0] retire_value
);
    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic [TAG_W-1:0]          alloc_tag, lookup_tag1, lookup_tag2, retire_tag;
    logic                      lookup_ready1, lookup_ready2;
    logic [core_pkg::XLEN-1:0] lookup_value1, lookup_value2;
    logic                      result_valid;
    logic [TAG_W-1:0]          result_tag;
    logic [core_pkg::XLEN-1:0] result_value;

    dispatch_if #(.ROB_DEPTH(ROB_DEPTH)) dispatch_bus ();
    issue_if #(.ROB_DEPTH(ROB_DEPTH)) issue_bus ();

    decode_rename #(.ROB_DEPTH(ROB_DEPTH)) decode_rename_i (
        .clk(clk), .rst_n(rst_n),
        .inst_valid(inst_valid), .inst(inst),
        .dispatch(dispatch_bus.source),
        .alloc_tag(alloc_tag),
        .lookup_tag1(lookup_tag1), .lookup_tag2(lookup_tag2),
        .lookup_ready1(lookup_ready1), .lookup_ready2(lookup_ready2),
        .lookup_value1(lookup_value1), .lookup_value2(lookup_value2),
        .retire_valid(retire_valid), .retire_tag(retire_tag),
        .retire_rd(retire_rd), .retire_value(retire_value)
    );

    reservation_station #(.ROB_DEPTH(ROB_DEPTH)) reservation_station_i (
        .clk(clk), .rst_n(rst_n),
        .dispatch(dispatch_bus.sink),
        .issue(issue_bus.source),
        .result_valid(result_valid), .result_tag(result_tag), .result_value(result_value)
    );

    int_execute #(.ROB_DEPTH(ROB_DEPTH)) int_execute_i (
        .clk(clk), .rst_n(rst_n),
        .issue(issue_bus.sink),
        .result_valid(result_valid), .result_tag(result_tag), .result_value(result_value)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) reorder_buffer_i (
        .clk(clk), .rst_n(rst_n),
        .dispatch(dispatch_bus.sink),
        .alloc_tag(alloc_tag),
        .lookup_tag1(lookup_tag1), .lookup_tag2(lookup_tag2),
        .lookup_ready1(lookup_ready1), .lookup_ready2(lookup_ready2),
        .lookup_value1(lookup_value1), .lookup_value2(lookup_value2),
        .result_valid(result_valid), .result_tag(result_tag), .result_value(result_value),
        .retire_valid(retire_valid), .retire_tag(retire_tag),
        .retire_rd(retire_rd), .retire_value(retire_value),
        .credit_return(credit_return)
    );

endmodule

/* sim/core_asserts.sv */
module core_asserts #(
    parameter int ROB_DEPTH = core_pkg::DEFAULT_ROB_DEPTH
) (
    input logic                         clk,
    input logic                         rst_n,
    input logic [$clog2(ROB_DEPTH):0]   count,
    input logic [$clog2(ROB_DEPTH)-1:0] head,
    input logic                         retire_valid,
    input logic                         credit_return,
    input logic                         result_valid,
    input logic [$clog2(ROB_DEPTH)-1:0] result_tag
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic [ROB_DEPTH-1:0] delivered;  // result seen since the slot last retired

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            delivered <= '0;
        end else begin
            if (retire_valid) delivered[head] <= 1'b0;
            if (result_valid) delivered[result_tag] <= 1'b1;
        end
    end

    count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= (TAG_W+1)'(ROB_DEPTH))
        else $error("rob count above depth");

    // each credit moves the head by one slot
    credit_match: assert property (@(posedge clk) disable iff (!rst_n)
        head == $past(head) + TAG_W'($past(credit_return)))
        else $error("credit_return does not match a retirement");

    retire_done: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> delivered[head])
        else $error("retirement of a head entry that is not done");

    // outputs quiet once a reset edge has been taken
    quiet_reset: assert property (@(posedge clk)
        !rst_n |=> !retire_valid && !credit_return && !result_valid)
        else $error("control output high during reset");

endmodule

bind reorder_buffer core_asserts #(.ROB_DEPTH(ROB_DEPTH)) core_asserts_i (
    .clk(clk), .rst_n(rst_n),
    .count(count), .head(head),
    .retire_valid(retire_valid), .credit_return(credit_return),
    .result_valid(result_valid), .result_tag(result_tag)
);

/* sim/tb_ooo_core.sv */
module tb_ooo_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROB_DEPTH  = core_pkg::DEFAULT_ROB_DEPTH;
    localparam int NUM_INSTS  = 400;
    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        credit_return;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_value;

    logic [31:0] lfsr_state;
    logic [31:0] model_regs [8];  // only x0..x7 are used
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_value_q [$];
    int          sent;
    int          returned;
    int          retired;

    ooo_core_top #(.ROB_DEPTH(ROB_DEPTH)) ooo_core_top_i (
        .clk(clk), .rst_n(rst_n),
        .inst_valid(inst_valid), .inst(inst),
        .credit_return(credit_return),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_value(retire_value)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "stopping on first failure");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s expected 0x%h got 0x%h", name, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic wait_for_return();
        int start;
        int cycles;
        start  = returned;
        cycles = 0;
        while (returned == start) begin
            if (cycles == WAIT_LIMIT) begin
                abort_run("timeout: no credit came back within 200 cycles");
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    task automatic send_random();
        logic [2:0]  sel;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm;
        logic [31:0] a, b, result;
        sel = 3'(rand_bits(3));
        rd  = 5'(rand_bits(3));  // small register set makes dependencies
        rs1 = 5'(rand_bits(3));
        rs2 = 5'(rand_bits(3));
        imm = 12'(rand_bits(12));
        a   = model_regs[rs1[2:0]];
        b   = model_regs[rs2[2:0]];
        case (sel)
            3'd0: begin
                inst   = {isa_pkg::F7_BASE, rs2, rs1, isa_pkg::F3_ADD_SUB, rd, isa_pkg::OPC_OP};
                result = a + b;
            end
            3'd1: begin
                inst   = {isa_pkg::F7_SUB, rs2, rs1, isa_pkg::F3_ADD_SUB, rd, isa_pkg::OPC_OP};
                result = a - b;
            end
            3'd2: begin
                inst   = {isa_pkg::F7_BASE, rs2, rs1, isa_pkg::F3_AND, rd, isa_pkg::OPC_OP};
                result = a & b;
            end
            3'd3: begin
                inst   = {isa_pkg::F7_BASE, rs2, rs1, isa_pkg::F3_OR, rd, isa_pkg::OPC_OP};
                result = a | b;
            end
            3'd4: begin
                inst   = {isa_pkg::F7_BASE, rs2, rs1, isa_pkg::F3_XOR, rd, isa_pkg::OPC_OP};
                result = a ^ b;
            end
            3'd6: begin
                inst   = {isa_pkg::F7_MULDIV, rs2, rs1, isa_pkg::F3_ADD_SUB, rd, isa_pkg::OPC_OP};
                result = a * b;  // low 32 bits
            end
            default: begin
                inst   = {imm, rs1, isa_pkg::F3_ADD_SUB, rd, isa_pkg::OPC_OP_IMM};
                result = a + {{20{imm[11]}}, imm};
            end
        endcase
        if (rd != 5'd0) model_regs[rd[2:0]] = result;  // x0 reads stay zero
        exp_rd_q.push_back(rd);
        exp_value_q.push_back(result);
        inst_valid = 1'b1;
        sent++;
    endtask

    // retire side, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            check("credit_return", 32'(retire_valid), 32'(credit_return));
            if (credit_return) returned++;
            if (retire_valid) begin
                if (exp_rd_q.size() == 0) begin
                    abort_run("retirement seen with no instruction outstanding");
                end else begin
                    check("retire_rd", 32'(exp_rd_q.pop_front()), 32'(retire_rd));
                    check("retire_value", exp_value_q.pop_front(), retire_value);
                    retired++;
                end
            end
        end
    end

    initial begin
        logic [3:0] gap;
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        lfsr_state = 32'd70;
        sent       = 0;
        returned   = 0;
        retired    = 0;
        for (int r = 0; r < 8; r++) begin
            model_regs[r] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (10) next_cycle();  // idle, nothing may retire
        while (sent < NUM_INSTS) begin
            gap = 4'(rand_bits(4));
            if (gap == 4'd0) begin
                repeat (20) next_cycle();  // let the window drain
            end else if (gap > 4'd2) begin
                while (sent - returned == ROB_DEPTH) wait_for_return();
                send_random();
            end
            next_cycle();
        end
        while (returned != sent) wait_for_return();
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* verilog.f */
common/isa_pkg.sv
common/core_pkg.sv
common/dispatch_if.sv
common/issue_if.sv
rename/decode_rename.sv
issue/reservation_station.sv
execute/int_execute.sv
retire/reorder_buffer.sv
source/ooo_core_top.sv
sim/core_asserts.sv
sim/tb_ooo_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ooo_core -f verilog.f -o tb_ooo_core
./obj_dir/tb_ooo_core
